// File: hw/yolo_cfg_pkg.sv
package yolo_cfg_pkg;

   // bus and field widths
   localparam int io_addr_w    = 32;
   localparam int half_addr_w  = 16;
   localparam int axi_len_w    = 8;
   localparam int pixel_addr_w = 10;
   localparam int cpu_addr_w   = 5;

   // stages fed with an external base address
   localparam int n_stages = 4;

   // cpu register map
   typedef enum logic [cpu_addr_w-1:0] {
      cfg_vread_ext_addr,
      cfg_vread_offset,
      cfg_vread_len,
      cfg_vread_int_addr,
      cfg_vread_pp,
      cfg_vread_iter_a,
      cfg_vread_start_b,
      cfg_vread_iter_b,
      cfg_vread_per_b,
      cfg_vread_shift_b,
      cfg_vread_incr_b,
      cfg_vwrite_len
   } cfg_addr_e;

   typedef enum logic [1:0] {
      gen_idle,
      gen_load,
      gen_run
   } gen_state_e;

   typedef struct packed {
      logic                 valid;
      cfg_addr_e            addr;
      logic [io_addr_w-1:0] wdata;
      logic                 wstrb;
   } cpu_req_t;

   // two-level B-port loop settings
   typedef struct packed {
      logic [pixel_addr_w-1:0] start;
      logic [pixel_addr_w-1:0] iterations;
      logic [pixel_addr_w-1:0] period;
      logic [pixel_addr_w-1:0] shift;
      logic [pixel_addr_w-1:0] incr;
   } gen_cfg_t;

   typedef struct packed {
      logic [io_addr_w-1:0]    ext_addr;
      logic [half_addr_w-1:0]  offset;
      logic [half_addr_w-1:0]  vread_len;
      logic [pixel_addr_w-1:0] int_addr;
      logic                    pp;
      logic [pixel_addr_w-1:0] iter_a;
      gen_cfg_t                gen;
      logic [axi_len_w-1:0]    vwrite_len;
   } cfg_t;

   // addr[0] is stage 0
   typedef struct packed {
      logic [n_stages-1:0][io_addr_w-1:0] addr;
   } stage_addr_t;

   typedef struct packed {
      logic [axi_len_w-1:0] vwrite_len;
      logic [axi_len_w-1:0] vread_len;
   } dma_len_t;

   typedef struct packed {
      logic                    en;
      logic [pixel_addr_w-1:0] addr;
   } bport_t;

endpackage

// File: hw/cfg_regs.sv
`timescale 1ns/1ps

module cfg_regs (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   clear,
   input  yolo_cfg_pkg::cpu_req_t req,
   output yolo_cfg_pkg::cfg_t     cfg
);

   logic wr_en;

   // a write needs valid and strobe in the same cycle
   assign wr_en = req.valid & req.wstrb;

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         cfg <= '0;
      end else if (clear) begin
         cfg <= '0;
      end else if (wr_en) begin
         case (req.addr)
            yolo_cfg_pkg::cfg_vread_ext_addr: begin
               cfg.ext_addr <= req.wdata;
            end
            yolo_cfg_pkg::cfg_vread_offset: begin
               cfg.offset <= req.wdata[yolo_cfg_pkg::half_addr_w-1:0];
            end
            yolo_cfg_pkg::cfg_vread_len: begin
               cfg.vread_len <= req.wdata[yolo_cfg_pkg::half_addr_w-1:0];
            end
            yolo_cfg_pkg::cfg_vread_int_addr: begin
               cfg.int_addr <= req.wdata[yolo_cfg_pkg::pixel_addr_w-1:0];
            end
            yolo_cfg_pkg::cfg_vread_pp: begin
               cfg.pp <= req.wdata[0];
            end
            yolo_cfg_pkg::cfg_vread_iter_a: begin
               cfg.iter_a <= req.wdata[yolo_cfg_pkg::pixel_addr_w-1:0];
            end
            // B-port generator
            yolo_cfg_pkg::cfg_vread_start_b: begin
               cfg.gen.start <= req.wdata[yolo_cfg_pkg::pixel_addr_w-1:0];
            end
            yolo_cfg_pkg::cfg_vread_iter_b: begin
               cfg.gen.iterations <= req.wdata[yolo_cfg_pkg::pixel_addr_w-1:0];
            end
            yolo_cfg_pkg::cfg_vread_per_b: begin
               cfg.gen.period <= req.wdata[yolo_cfg_pkg::pixel_addr_w-1:0];
            end
            yolo_cfg_pkg::cfg_vread_shift_b: begin
               cfg.gen.shift <= req.wdata[yolo_cfg_pkg::pixel_addr_w-1:0];
            end
            yolo_cfg_pkg::cfg_vread_incr_b: begin
               cfg.gen.incr <= req.wdata[yolo_cfg_pkg::pixel_addr_w-1:0];
            end
            yolo_cfg_pkg::cfg_vwrite_len: begin
               cfg.vwrite_len <= req.wdata[yolo_cfg_pkg::axi_len_w-1:0];
            end
            // unmapped addresses are dropped
            default: begin
            end
         endcase
      end
   end

endmodule

// File: hw/cfg_shadow.sv
`timescale 1ns/1ps

module cfg_shadow (
   input  logic                      clk,
   input  logic                      rst,
   input  logic                      run,
   input  yolo_cfg_pkg::cfg_t        cfg,
   output yolo_cfg_pkg::cfg_t        shadow,
   output yolo_cfg_pkg::stage_addr_t stage_addr
);

   logic [yolo_cfg_pkg::io_addr_w-1:0] offset_ext;
   yolo_cfg_pkg::cfg_t                 shadow_next;
   yolo_cfg_pkg::stage_addr_t          stage_addr_next;

   assign offset_ext = {{(yolo_cfg_pkg::io_addr_w - yolo_cfg_pkg::half_addr_w){1'b0}},
                        cfg.offset};

   // base plus stage index times offset
   always_comb begin
      for (int i = 0; i < yolo_cfg_pkg::n_stages; i++) begin
         stage_addr_next.addr[i] = cfg.ext_addr + offset_ext * i;
      end
   end

   always_comb begin
      shadow_next = cfg;
      // ping-pong: msb flips against the previous run when iter_a is set
      if (cfg.pp) begin
         shadow_next.int_addr = {
            shadow.int_addr[yolo_cfg_pkg::pixel_addr_w-1] ^ (|cfg.iter_a),
            cfg.int_addr[yolo_cfg_pkg::pixel_addr_w-2:0]
         };
      end
   end

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         shadow     <= '0;
         stage_addr <= '0;
      end else if (run) begin
         shadow     <= shadow_next;
         stage_addr <= stage_addr_next;
      end
   end

endmodule

// File: hw/addr_gen.sv
`timescale 1ns/1ps

module addr_gen (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   start,
   input  yolo_cfg_pkg::gen_cfg_t gen,
   output yolo_cfg_pkg::bport_t   bport,
   output logic                   done
);

   yolo_cfg_pkg::gen_state_e              state;
   logic [yolo_cfg_pkg::pixel_addr_w-1:0] inner_cnt;
   logic [yolo_cfg_pkg::pixel_addr_w-1:0] outer_cnt;
   // accumulated k*shift and j*incr
   logic [yolo_cfg_pkg::pixel_addr_w-1:0] base;
   logic [yolo_cfg_pkg::pixel_addr_w-1:0] step;
   logic                                  inner_last;
   logic                                  outer_last;

   assign inner_last = (inner_cnt == gen.period - 1'b1);
   assign outer_last = (outer_cnt == gen.iterations - 1'b1);

   assign bport.en   = (state == yolo_cfg_pkg::gen_run);
   assign bport.addr = gen.start + base + step;

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         state     <= yolo_cfg_pkg::gen_idle;
         done      <= 1'b1;
         inner_cnt <= '0;
         outer_cnt <= '0;
         base      <= '0;
         step      <= '0;
      end else if (start) begin
         // restarts from any state
         state <= yolo_cfg_pkg::gen_load;
         done  <= 1'b0;
      end else begin
         case (state)
            yolo_cfg_pkg::gen_load: begin
               inner_cnt <= '0;
               outer_cnt <= '0;
               base      <= '0;
               step      <= '0;
               if (gen.iterations == '0 || gen.period == '0) begin
                  state <= yolo_cfg_pkg::gen_idle;
                  done  <= 1'b1;
               end else begin
                  state <= yolo_cfg_pkg::gen_run;
               end
            end
            yolo_cfg_pkg::gen_run: begin
               if (!inner_last) begin
                  inner_cnt <= inner_cnt + 1'b1;
                  step      <= step + gen.incr;
               end else if (!outer_last) begin
                  inner_cnt <= '0;
                  step      <= '0;
                  outer_cnt <= outer_cnt + 1'b1;
                  base      <= base + gen.shift;
               end else begin
                  state <= yolo_cfg_pkg::gen_idle;
                  done  <= 1'b1;
               end
            end
            default: begin
            end
         endcase
      end
   end

endmodule

// File: hw/dma_len_ctrl.sv
`timescale 1ns/1ps

module dma_len_ctrl (
   input  logic                                 clk,
   input  logic                                 rst,
   input  logic                                 run,
   input  logic                                 ready,
   input  logic [yolo_cfg_pkg::half_addr_w-1:0] vread_len,
   input  logic [yolo_cfg_pkg::half_addr_w-1:0] vread_len_shadow,
   input  logic [yolo_cfg_pkg::axi_len_w-1:0]   vwrite_len,
   output yolo_cfg_pkg::dma_len_t               dma_len
);

   logic [yolo_cfg_pkg::half_addr_w-1:0] dma_cnt;
   logic                                 over_range;

   // remaining vread beats, reloaded from the shadow when it runs out
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         dma_cnt <= '0;
      end else if (run) begin
         dma_cnt <= vread_len;
      end else if (ready) begin
         if (dma_cnt == '0) begin
            dma_cnt <= vread_len_shadow;
         end else begin
            dma_cnt <= dma_cnt - 1'b1;
         end
      end
   end

   assign over_range = |dma_cnt[yolo_cfg_pkg::half_addr_w-1:yolo_cfg_pkg::axi_len_w];

   // saturate at the largest burst
   assign dma_len.vread_len  = over_range ? '1 : dma_cnt[yolo_cfg_pkg::axi_len_w-1:0];
   assign dma_len.vwrite_len = vwrite_len;

endmodule

// File: hw/yolo_write_ctrl.sv
`timescale 1ns/1ps

module yolo_write_ctrl (
   input  logic                                  clk,
   input  logic                                  rst,
   input  logic                                  clear,
   input  logic                                  run,
   input  logic                                  ready,
   input  yolo_cfg_pkg::cpu_req_t                req,
   output yolo_cfg_pkg::stage_addr_t             stage_addr,
   output logic [yolo_cfg_pkg::pixel_addr_w-1:0] int_addr,
   output yolo_cfg_pkg::bport_t                  bport,
   output yolo_cfg_pkg::dma_len_t                dma_len,
   output logic                                  done
);

   yolo_cfg_pkg::cfg_t cfg;
   yolo_cfg_pkg::cfg_t shadow;
   logic               run_reg;

   // generator starts once the shadow holds the new values
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         run_reg <= 1'b0;
      end else begin
         run_reg <= run;
      end
   end

   cfg_regs i_cfg_regs (
      .clk   (clk),
      .rst   (rst),
      .clear (clear),
      .req   (req),
      .cfg   (cfg)
   );

   cfg_shadow i_cfg_shadow (
      .clk        (clk),
      .rst        (rst),
      .run        (run),
      .cfg        (cfg),
      .shadow     (shadow),
      .stage_addr (stage_addr)
   );

   assign int_addr = shadow.int_addr;

   addr_gen i_addr_gen (
      .clk   (clk),
      .rst   (rst),
      .start (run_reg),
      .gen   (shadow.gen),
      .bport (bport),
      .done  (done)
   );

   // live length on run, shadow length on reload
   dma_len_ctrl i_dma_len_ctrl (
      .clk              (clk),
      .rst              (rst),
      .run              (run),
      .ready            (ready),
      .vread_len        (cfg.vread_len),
      .vread_len_shadow (shadow.vread_len),
      .vwrite_len       (shadow.vwrite_len),
      .dma_len          (dma_len)
   );

endmodule

// File: testbench/yolo_write_ctrl_checker.sv
`timescale 1ns/1ps

module yolo_write_ctrl_checker (
   input logic                                 clk,
   input logic                                 rst,
   input logic                                 run_reg,
   input logic                                 done,
   input yolo_cfg_pkg::bport_t                 bport,
   input yolo_cfg_pkg::dma_len_t               dma_len,
   input logic [yolo_cfg_pkg::half_addr_w-1:0] dma_cnt
);

   // generator busy and finished are exclusive
   en_done_excl: assert property (@(posedge clk) disable iff (rst) !(bport.en && done))
      else $error("B-port enable and done high in the same cycle");

   done_drop: assert property (@(posedge clk) disable iff (rst) run_reg |=> !done)
      else $error("done still high one cycle after run_reg");

   // counter above the burst range saturates the length
   len_sat: assert property (@(posedge clk) disable iff (rst)
      ((dma_cnt >> yolo_cfg_pkg::axi_len_w) != 0) |-> (dma_len.vread_len == '1))
      else $error("vread dma length not saturated");

endmodule

bind yolo_write_ctrl yolo_write_ctrl_checker i_yolo_write_ctrl_checker (
   .clk     (clk),
   .rst     (rst),
   .run_reg (run_reg),
   .done    (done),
   .bport   (bport),
   .dma_len (dma_len),
   .dma_cnt (i_dma_len_ctrl.dma_cnt)
);

// File: testbench/tb_yolo_write_ctrl.sv
`timescale 1ns/1ps

module tb_yolo_write_ctrl;

   localparam int done_timeout = 200;

   logic clk = 1'b0;
   logic rst;
   logic clear;
   logic run;
   logic ready;
   yolo_cfg_pkg::cpu_req_t                req;
   yolo_cfg_pkg::stage_addr_t             stage_addr;
   logic [yolo_cfg_pkg::pixel_addr_w-1:0] int_addr;
   yolo_cfg_pkg::bport_t                  bport;
   yolo_cfg_pkg::dma_len_t                dma_len;
   logic                                  done;

   // model state
   yolo_cfg_pkg::cfg_t                    m_cfg;
   yolo_cfg_pkg::cfg_t                    m_shadow;
   yolo_cfg_pkg::stage_addr_t             m_stage;
   logic [yolo_cfg_pkg::half_addr_w-1:0]  m_cnt;
   logic [yolo_cfg_pkg::pixel_addr_w-1:0] exp_q[$];
   int                                    gen_wait;

   integer seed;
   int     error_count;
   bit     aborted;
   int     r;

   always #4 clk = ~clk;

   yolo_write_ctrl i_yolo_write_ctrl (
      .clk        (clk),
      .rst        (rst),
      .clear      (clear),
      .run        (run),
      .ready      (ready),
      .req        (req),
      .stage_addr (stage_addr),
      .int_addr   (int_addr),
      .bport      (bport),
      .dma_len    (dma_len),
      .done       (done)
   );

   task automatic check_stage_addr(input yolo_cfg_pkg::stage_addr_t got,
                                   input yolo_cfg_pkg::stage_addr_t exp);
      int i;
      for (i = 0; i < yolo_cfg_pkg::n_stages; i++) begin
         if (got.addr[i] !== exp.addr[i]) begin
            $display("ERR stage_addr[%0d] got %h exp %h", i, got.addr[i], exp.addr[i]);
            error_count++;
         end
      end
   endtask

   task automatic check_int_addr(input logic [yolo_cfg_pkg::pixel_addr_w-1:0] got,
                                 input logic [yolo_cfg_pkg::pixel_addr_w-1:0] exp);
      if (got !== exp) begin
         $display("ERR int_addr got %h exp %h", got, exp);
         error_count++;
      end
   endtask

   // address only matters while enabled
   task automatic check_bport(input yolo_cfg_pkg::bport_t got, input yolo_cfg_pkg::bport_t exp);
      if (got.en !== exp.en || (exp.en && got.addr !== exp.addr)) begin
         $display("ERR bport got en %h addr %h exp en %h addr %h",
                  got.en, got.addr, exp.en, exp.addr);
         error_count++;
      end
   endtask

   task automatic check_dma_len(input yolo_cfg_pkg::dma_len_t got,
                                input yolo_cfg_pkg::dma_len_t exp);
      if (got !== exp) begin
         $display("ERR dma_len got vwrite %h vread %h exp vwrite %h vread %h",
                  got.vwrite_len, got.vread_len, exp.vwrite_len, exp.vread_len);
         error_count++;
      end
   endtask

   task automatic model_write(input logic [yolo_cfg_pkg::cpu_addr_w-1:0] a,
                              input logic [yolo_cfg_pkg::io_addr_w-1:0] d);
      case (a)
         yolo_cfg_pkg::cfg_vread_ext_addr: m_cfg.ext_addr = d;
         yolo_cfg_pkg::cfg_vread_offset:   m_cfg.offset = d[15:0];
         yolo_cfg_pkg::cfg_vread_len:      m_cfg.vread_len = d[15:0];
         yolo_cfg_pkg::cfg_vread_int_addr: m_cfg.int_addr = d[9:0];
         yolo_cfg_pkg::cfg_vread_pp:       m_cfg.pp = d[0];
         yolo_cfg_pkg::cfg_vread_iter_a:   m_cfg.iter_a = d[9:0];
         yolo_cfg_pkg::cfg_vread_start_b:  m_cfg.gen.start = d[9:0];
         yolo_cfg_pkg::cfg_vread_iter_b:   m_cfg.gen.iterations = d[9:0];
         yolo_cfg_pkg::cfg_vread_per_b:    m_cfg.gen.period = d[9:0];
         yolo_cfg_pkg::cfg_vread_shift_b:  m_cfg.gen.shift = d[9:0];
         yolo_cfg_pkg::cfg_vread_incr_b:   m_cfg.gen.incr = d[9:0];
         yolo_cfg_pkg::cfg_vwrite_len:     m_cfg.vwrite_len = d[7:0];
         default: ;
      endcase
   endtask

   // shadow capture, stage addresses and the expected B-port sequence
   task automatic model_run();
      yolo_cfg_pkg::cfg_t                    nxt;
      logic [yolo_cfg_pkg::io_addr_w-1:0]    off;
      logic [yolo_cfg_pkg::pixel_addr_w-1:0] a;
      int i;
      int k;
      int j;
      nxt = m_cfg;
      if (m_cfg.pp) begin
         nxt.int_addr[9] = m_shadow.int_addr[9] ^ (m_cfg.iter_a != 0);
      end
      m_shadow = nxt;
      off = m_cfg.offset;
      for (i = 0; i < yolo_cfg_pkg::n_stages; i++) begin
         m_stage.addr[i] = m_cfg.ext_addr + off * i;
      end
      exp_q.delete();
      for (k = 0; k < nxt.gen.iterations; k++) begin
         for (j = 0; j < nxt.gen.period; j++) begin
            a = nxt.gen.start + k * nxt.gen.shift + j * nxt.gen.incr;
            exp_q.push_back(a);
         end
      end
      // capture edge, start edge, load edge, then enables
      gen_wait = 3;
   endtask

   // one clock with the inputs already driven, then check on the falling edge
   task automatic cycle();
      yolo_cfg_pkg::dma_len_t exp_len;
      yolo_cfg_pkg::bport_t   exp_b;
      if (run) begin
         m_cnt = m_cfg.vread_len;
      end else if (ready) begin
         m_cnt = (m_cnt == 0) ? m_shadow.vread_len : m_cnt - 1'b1;
      end
      if (run) begin
         model_run();
      end
      if (clear) begin
         m_cfg = '0;
      end else if (req.valid && req.wstrb) begin
         model_write(req.addr, req.wdata);
      end
      @(posedge clk);
      @(negedge clk);
      check_stage_addr(stage_addr, m_stage);
      check_int_addr(int_addr, m_shadow.int_addr);
      exp_len.vwrite_len = m_shadow.vwrite_len;
      exp_len.vread_len  = (m_cnt > 16'h00ff) ? 8'hff : m_cnt[7:0];
      check_dma_len(dma_len, exp_len);
      if (gen_wait > 0) begin
         gen_wait--;
      end
      if (bport.en && exp_q.size() == 0) begin
         $display("B-port enable seen with no address left in the expected sequence");
         error_count++;
      end else begin
         exp_b.en   = (gen_wait == 0) && (exp_q.size() != 0);
         exp_b.addr = '0;
         if (exp_b.en) begin
            exp_b.addr = exp_q.pop_front();
         end
         check_bport(bport, exp_b);
      end
   endtask

   task automatic write_reg(input yolo_cfg_pkg::cfg_addr_e a, input logic [31:0] d);
      req.valid = 1'b1;
      req.wstrb = 1'b1;
      req.addr  = a;
      req.wdata = d;
      cycle();
      req.valid = 1'b0;
      req.wstrb = 1'b0;
   endtask

   // includes dropped strobes and unmapped addresses
   task automatic write_random();
      logic [31:0] rnd;
      logic [31:0] d;
      logic [4:0]  a;
      rnd = $random(seed);
      d   = $random(seed);
      a   = (rnd[3:0] < 12) ? {1'b0, rnd[3:0]} : {1'b0, rnd[7:4]} + 5'd12;
      case (a)
         yolo_cfg_pkg::cfg_vread_iter_b, yolo_cfg_pkg::cfg_vread_per_b: d = d & 32'd7;
         yolo_cfg_pkg::cfg_vread_iter_a: d = d & 32'd3;
         yolo_cfg_pkg::cfg_vread_len: d = rnd[12] ? (d & 32'd15) : (d & 32'h3ff);
         default: ;
      endcase
      req.valid = (rnd[10:8] != 3'd0);
      req.wstrb = (rnd[10:8] != 3'd1);
      req.addr  = yolo_cfg_pkg::cfg_addr_e'(a);
      req.wdata = d;
      ready     = rnd[11];
      cycle();
      req.valid = 1'b0;
      req.wstrb = 1'b0;
   endtask

   task automatic run_and_wait();
      int n;
      run   = 1'b1;
      ready = $random(seed);
      cycle();
      run   = 1'b0;
      ready = $random(seed);
      cycle();
      if (done) begin
         $display("done did not drop after the run pulse");
         error_count++;
      end
      n = 0;
      while (!done && n < done_timeout) begin
         ready = $random(seed);
         cycle();
         n++;
      end
      if (!done) begin
         $display("timeout after %0d cycles waiting for done", done_timeout);
         error_count++;
         aborted = 1'b1;
      end else if (exp_q.size() != 0) begin
         $display("run ended with %0d expected addresses never enabled", exp_q.size());
         error_count++;
         exp_q.delete();
      end
   endtask

   initial begin
      seed        = 32'h1a00_6646;
      error_count = 0;
      aborted     = 1'b0;
      rst         = 1'b1;
      clear       = 1'b0;
      run         = 1'b0;
      ready       = 1'b0;
      req         = '0;
      m_cfg       = '0;
      m_shadow    = '0;
      m_stage     = '0;
      m_cnt       = '0;
      gen_wait    = 0;
      repeat (8) @(negedge clk);
      rst = 1'b0;
      if (!done || bport.en) begin
         $display("outputs not idle after reset");
         error_count++;
      end
      for (r = 0; r < 24 && !aborted; r++) begin
         repeat (8) write_random();
         run_and_wait();
      end
      // ping-pong toggles across runs
      write_reg(yolo_cfg_pkg::cfg_vread_pp, 32'd1);
      write_reg(yolo_cfg_pkg::cfg_vread_iter_a, 32'd5);
      write_reg(yolo_cfg_pkg::cfg_vread_int_addr, $random(seed));
      for (r = 0; r < 4 && !aborted; r++) begin
         run_and_wait();
      end
      write_reg(yolo_cfg_pkg::cfg_vread_pp, 32'd0);
      if (!aborted) run_and_wait();
      // cleared config gives zero addresses and no enables
      clear = 1'b1;
      cycle();
      clear = 1'b0;
      if (!aborted) run_and_wait();
      $display("error count: %0d", error_count);
      if (error_count == 0) begin
         $display("NO ERRORS");
      end else begin
         $display("ERRORS FOUND");
      end
      $finish;
   end

endmodule

// File: build.f
hw/yolo_cfg_pkg.sv
hw/cfg_regs.sv
hw/cfg_shadow.sv
hw/addr_gen.sv
hw/dma_len_ctrl.sv
hw/yolo_write_ctrl.sv
testbench/yolo_write_ctrl_checker.sv
testbench/tb_yolo_write_ctrl.sv

// File: Bender.yml
package:
  name: yolo_write_ctrl

sources:
  - files:
      - hw/yolo_cfg_pkg.sv
      - hw/cfg_regs.sv
      - hw/cfg_shadow.sv
      - hw/addr_gen.sv
      - hw/dma_len_ctrl.sv
      - hw/yolo_write_ctrl.sv
  - target: simulation
    files:
      - testbench/yolo_write_ctrl_checker.sv
      - testbench/tb_yolo_write_ctrl.sv
